// File: rtl/sparse_defines.svh
`ifndef SPARSE_DEFINES_SVH
`define SPARSE_DEFINES_SVH

////////////////////
// Fixed-point word split, signed Q8.12
`define SP_INT_BITS 8
`define SP_FRAC_BITS 12
`define SP_WORD_BITS (`SP_INT_BITS + `SP_FRAC_BITS)

////////////////////
// Job shape

// Activation/weight pairs per job
`define SP_LANES 16

// Kept-pair count, 0 to SP_LANES inclusive
`define SP_CNT_BITS 5

// Lane index, 0 to SP_LANES-1
`define SP_IDX_BITS 4

// One packed operand vector, lane 0 in the low bits
`define SP_VEC_BITS (`SP_LANES * `SP_WORD_BITS)

`endif

// File: rtl/sparse_data_pkg.sv
`include "sparse_defines.svh"

package sparse_data_pkg;

////////////////////
// Payload types

// One signed fixed-point value
typedef logic signed [`SP_WORD_BITS-1:0] word_t;

// All lanes of one operand
typedef logic [`SP_VEC_BITS-1:0] lane_vec_t;

////////////////////
// Bookkeeping types

typedef logic [`SP_LANES-1:0] mask_t;     // One bit per lane
typedef logic [`SP_CNT_BITS-1:0] count_t; // Kept pairs in a job

endpackage

// File: rtl/sparse_ctrl_pkg.sv
package sparse_ctrl_pkg;

// Compactor FSM
typedef enum logic [1:0] {
	IDLE = 2'b00, // Waiting for a filtered job
	SCAN = 2'b01, // One lane per cycle
	HOLD = 2'b10  // Result on the output until taken
} compact_state_t;

endpackage

// File: rtl/lane_filter.sv
`timescale 1ns/1ps
`include "sparse_defines.svh"

module lane_filter
	import sparse_data_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      i_valid,
	input  lane_vec_t i_act,
	input  lane_vec_t i_wgt,
	input  mask_t     i_act_mask,
	input  mask_t     i_wgt_mask,
	input  logic      i_ready,
	output logic      o_ready,
	output logic      o_valid,
	output lane_vec_t o_act,
	output lane_vec_t o_wgt,
	output mask_t     o_mask
);

logic full;       // Slot holds a job
logic accept;
mask_t joint;
lane_vec_t act_keep;
lane_vec_t wgt_keep;

////////////////////
// Handshake

// Take a new job when empty, or when the held one leaves this cycle
assign o_ready = !full || i_ready;
assign accept = i_valid && o_ready;
assign o_valid = full;

always_ff @(posedge clk) begin
	if (reset) begin
		full <= 1'b0;
	end
	else if (accept) begin
		full <= 1'b1;
	end
	else if (i_ready) begin
		full <= 1'b0; // Job went to the compactor
	end
end

////////////////////
// Lane filter

always_comb begin
	joint = i_act_mask & i_wgt_mask;
	for (int l = 0; l < `SP_LANES; l++) begin
		// Dead lane in either operand zeroes the pair
		act_keep[l*`SP_WORD_BITS +: `SP_WORD_BITS] =
			joint[l] ? i_act[l*`SP_WORD_BITS +: `SP_WORD_BITS] : '0;
		wgt_keep[l*`SP_WORD_BITS +: `SP_WORD_BITS] =
			joint[l] ? i_wgt[l*`SP_WORD_BITS +: `SP_WORD_BITS] : '0;
	end
end

always_ff @(posedge clk) begin
	if (accept) begin
		o_act <= act_keep;
		o_wgt <= wgt_keep;
		o_mask <= joint;
	end
end

// Stalled job stays put until the compactor takes it
property p_stall_stable;
	@(posedge clk) disable iff (reset)
	o_valid && !i_ready |=> o_valid && $stable(o_act) && $stable(o_wgt) && $stable(o_mask);
endproperty

a_stall_stable: assert property (p_stall_stable)
	else $error("lane_filter: output changed while waiting for the compactor");

endmodule

// File: rtl/pair_compactor.sv
`timescale 1ns/1ps
`include "sparse_defines.svh"

module pair_compactor
	import sparse_data_pkg::*, sparse_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      i_valid,
	input  lane_vec_t i_act,
	input  lane_vec_t i_wgt,
	input  mask_t     i_mask,
	input  logic      i_ready,
	output logic      o_ready,
	output logic      o_valid,
	output lane_vec_t o_act,
	output lane_vec_t o_wgt,
	output mask_t     o_mask,
	output count_t    o_count
);

compact_state_t state;
logic [`SP_IDX_BITS-1:0] lane_idx; // Lane under scan
count_t wr_ptr;                    // Next free output slot
logic accept;
logic last_lane;

// Captured job
lane_vec_t src_act;
lane_vec_t src_wgt;
mask_t src_mask;

// Current lane
word_t cur_act;
word_t cur_wgt;
logic cur_live;

////////////////////
// Handshake

assign o_ready = (state == IDLE);
assign o_valid = (state == HOLD);
assign accept = i_valid && o_ready;
assign last_lane = (lane_idx == `SP_IDX_BITS'(`SP_LANES - 1));

////////////////////
// FSM

always_ff @(posedge clk) begin
	if (reset) begin
		state <= IDLE;
		lane_idx <= '0;
		wr_ptr <= '0;
	end
	else begin
		case (state)
			IDLE: begin
				if (accept) begin
					state <= SCAN;
					lane_idx <= '0;
					wr_ptr <= '0;
				end
			end
			SCAN: begin
				lane_idx <= lane_idx + 1'b1;
				if (cur_live) begin
					wr_ptr <= wr_ptr + 1'b1;
				end
				if (last_lane) begin
					state <= HOLD;
				end
			end
			HOLD: begin
				if (i_ready) begin
					state <= IDLE;
				end
			end
			default: state <= IDLE;
		endcase
	end
end

////////////////////
// Datapath

always_comb begin
	cur_act = src_act[lane_idx*`SP_WORD_BITS +: `SP_WORD_BITS];
	cur_wgt = src_wgt[lane_idx*`SP_WORD_BITS +: `SP_WORD_BITS];
	cur_live = src_mask[lane_idx];
end

always_ff @(posedge clk) begin
	if (accept) begin
		src_act <= i_act;
		src_wgt <= i_wgt;
		src_mask <= i_mask;
		o_act <= '0; // Unused upper lanes read zero
		o_wgt <= '0;
	end
	else if (state == SCAN && cur_live) begin
		// Kept pair moves down to the next free slot, order preserved
		o_act[wr_ptr*`SP_WORD_BITS +: `SP_WORD_BITS] <= cur_act;
		o_wgt[wr_ptr*`SP_WORD_BITS +: `SP_WORD_BITS] <= cur_wgt;
	end
end

assign o_count = wr_ptr;

// Lowest o_count bits set
always_comb begin
	for (int l = 0; l < `SP_LANES; l++) begin
		o_mask[l] = (l < int'(wr_ptr));
	end
end

// Result count matches the live lanes of the captured job
a_count_range: assert property (@(posedge clk) disable iff (reset)
	o_valid |-> o_count <= `SP_LANES && o_count == count_t'($countones(src_mask)))
	else $error("pair_compactor: kept-pair count out of range or wrong");

// Result appears after exactly SP_LANES scan cycles
a_valid_hold: assert property (@(posedge clk) disable iff (reset)
	$rose(o_valid) |-> $past(state, `SP_LANES) == SCAN && $past(state, `SP_LANES + 1) == IDLE)
	else $error("pair_compactor: o_valid rose without a full scan of the job");

endmodule

// File: rtl/sparsity_top.sv
`timescale 1ns/1ps

module sparsity_top
	import sparse_data_pkg::*;
(
	input  logic      clk,
	input  logic      reset,

	// Job in
	input  logic      i_valid,
	input  lane_vec_t i_act,
	input  lane_vec_t i_wgt,
	input  mask_t     i_act_mask,
	input  mask_t     i_wgt_mask,
	output logic      o_ready,

	// Compacted job out
	input  logic      i_ready,
	output logic      o_valid,
	output lane_vec_t o_act,
	output lane_vec_t o_wgt,
	output mask_t     o_mask,
	output count_t    o_count
);

////////////////////
// Filter to compactor link

logic flt_valid;
logic flt_ready;
lane_vec_t flt_act;
lane_vec_t flt_wgt;
mask_t flt_mask; // Joint mask

////////////////////
// Stages

lane_filter filter_i (
	.clk        (clk),
	.reset      (reset),
	.i_valid    (i_valid),
	.i_act      (i_act),
	.i_wgt      (i_wgt),
	.i_act_mask (i_act_mask),
	.i_wgt_mask (i_wgt_mask),
	.i_ready    (flt_ready),
	.o_ready    (o_ready),
	.o_valid    (flt_valid),
	.o_act      (flt_act),
	.o_wgt      (flt_wgt),
	.o_mask     (flt_mask)
);

// Second job may wait in the filter while this one scans
pair_compactor compactor_i (
	.clk     (clk),
	.reset   (reset),
	.i_valid (flt_valid),
	.i_act   (flt_act),
	.i_wgt   (flt_wgt),
	.i_mask  (flt_mask),
	.i_ready (i_ready),
	.o_ready (flt_ready),
	.o_valid (o_valid),
	.o_act   (o_act),
	.o_wgt   (o_wgt),
	.o_mask  (o_mask),
	.o_count (o_count)
);

endmodule

// File: sim/tb_sparsity.sv
`timescale 1ns/1ps
`include "sparse_defines.svh"

module tb_sparsity
	import sparse_data_pkg::*;
();

localparam int CLK_NS = 40;
localparam int W = `SP_WORD_BITS;
localparam int N_ALL_ONES = 3;
localparam int N_DISJOINT = 4;
localparam int N_RANDOM = 200;
localparam int N_BACKPRESSURE = 40;
localparam int N_BURST = 20;
localparam int N_JOBS = N_ALL_ONES + N_DISJOINT + N_RANDOM + N_BACKPRESSURE + N_BURST;
localparam int LIMIT_CYCLES = N_JOBS * 25 + 200; // 18-cycle latency plus stall room

typedef struct packed {
	lane_vec_t act;
	lane_vec_t wgt;
	mask_t mask;
	count_t count;
} result_t;

logic clk;
logic reset;
logic i_valid;
lane_vec_t i_act;
lane_vec_t i_wgt;
mask_t i_act_mask;
mask_t i_wgt_mask;
logic i_ready;
logic o_ready;
logic o_valid;
lane_vec_t o_act;
lane_vec_t o_wgt;
mask_t o_mask;
count_t o_count;

result_t exp_q[$];   // Accepted jobs, oldest first
result_t exp_r;
logic [31:0] data_rng;
logic [31:0] rdy_rng;
int bp_left;
logic bp_enable;
int errors;
int checks;
int accepted_cnt;
int done_cnt;
logic overlap_seen;  // A job entered while another was in flight
logic holding;
result_t held;

sparsity_top dut_i (
	.clk        (clk),
	.reset      (reset),
	.i_valid    (i_valid),
	.i_act      (i_act),
	.i_wgt      (i_wgt),
	.i_act_mask (i_act_mask),
	.i_wgt_mask (i_wgt_mask),
	.o_ready    (o_ready),
	.i_ready    (i_ready),
	.o_valid    (o_valid),
	.o_act      (o_act),
	.o_wgt      (o_wgt),
	.o_mask     (o_mask),
	.o_count    (o_count)
);

initial begin
	clk = 1'b0;
	forever #(CLK_NS / 2) clk = ~clk;
end

////////////////////
// Random source and reference model

function automatic logic [31:0] lcg_step(input logic [31:0] s);
	return s * 32'd1103515245 + 32'd12345;
endfunction

// Keep pairs live in both masks, pack them down in order
function automatic result_t ref_compact(input lane_vec_t act, input lane_vec_t wgt,
		input mask_t am, input mask_t wm);
	result_t r;
	mask_t joint;
	int k;
	r = '0;
	joint = am & wm;
	k = 0;
	for (int l = 0; l < `SP_LANES; l++) begin
		if (joint[l]) begin
			r.act[k*W +: W] = act[l*W +: W];
			r.wgt[k*W +: W] = wgt[l*W +: W];
			k++;
		end
	end
	for (int l = 0; l < `SP_LANES; l++) begin
		r.mask[l] = (l < k);
	end
	r.count = count_t'(k);
	return r;
endfunction

task automatic make_rand_job(output lane_vec_t act, output lane_vec_t wgt,
		output mask_t am, output mask_t wm);
	for (int l = 0; l < `SP_LANES; l++) begin
		data_rng = lcg_step(data_rng);
		act[l*W +: W] = data_rng[31:12];
		data_rng = lcg_step(data_rng);
		wgt[l*W +: W] = data_rng[31:12];
	end
	data_rng = lcg_step(data_rng);
	am = data_rng[31:16];
	data_rng = lcg_step(data_rng);
	wm = data_rng[31:16];
endtask

////////////////////
// Stimulus

// Called at a rising edge, returns at the edge of the transfer
task automatic drive_job(input lane_vec_t act, input lane_vec_t wgt,
		input mask_t am, input mask_t wm);
	i_valid <= 1'b1;
	i_act <= act;
	i_wgt <= wgt;
	i_act_mask <= am;
	i_wgt_mask <= wm;
	do @(negedge clk); while (!o_ready);
	@(posedge clk);
endtask

// Kind 1 all ones, 2 disjoint, 3 random, 4 back-pressure, 5 burst
task automatic run_test(input int id, input string name, input int n_jobs, input int kind);
	lane_vec_t act;
	lane_vec_t wgt;
	mask_t am;
	mask_t wm;
	int base;
	base = errors;
	overlap_seen = 1'b0;
	bp_enable <= (kind == 4);
	for (int j = 0; j < n_jobs; j++) begin
		make_rand_job(act, wgt, am, wm);
		if (kind == 1) begin
			am = '1;
			wm = '1;
		end
		else if (kind == 2) begin
			case (j % 4)
				0: begin
					am = 16'hAAAA;
					wm = 16'h5555;
				end
				1: begin
					am = 16'h0000;
					wm = 16'hFFFF;
				end
				2: begin
					am = 16'hFFFF;
					wm = 16'h0000;
				end
				default: begin
					am = 16'hF0F0;
					wm = 16'h0F0F;
				end
			endcase
		end
		drive_job(act, wgt, am, wm);
	end
	i_valid <= 1'b0;
	while (done_cnt != accepted_cnt) @(posedge clk);
	bp_enable <= 1'b0;
	@(posedge clk);
	if (kind == 5) begin
		checks++;
		assert (overlap_seen) else begin
			$display("Error: no job was accepted while an earlier one was still in flight");
			errors++;
		end
	end
	$display("Test %0d %s: %0d jobs, %0d errors", id, name, n_jobs, errors - base);
endtask

// Random low stretches on i_ready while back-pressure is on
always @(posedge clk) begin
	if (!bp_enable) begin
		i_ready <= 1'b1;
		bp_left = 0;
	end
	else if (bp_left == 0) begin
		rdy_rng = lcg_step(rdy_rng);
		i_ready <= rdy_rng[27];
		bp_left = 1 + int'(rdy_rng[24:22]);
	end
	else begin
		bp_left--;
	end
end

////////////////////
// Comparison

task automatic compare_result(input result_t e);
	checks += 4;
	assert (o_act == e.act) else begin
		$display("Mismatch at %0t: job %0d o_act %h, expected %h", $time, done_cnt,
			o_act, e.act);
		errors++;
	end
	assert (o_wgt == e.wgt) else begin
		$display("Mismatch at %0t: job %0d o_wgt %h, expected %h", $time, done_cnt,
			o_wgt, e.wgt);
		errors++;
	end
	assert (o_mask == e.mask) else begin
		$display("Mismatch at %0t: job %0d o_mask %h, expected %h", $time, done_cnt,
			o_mask, e.mask);
		errors++;
	end
	assert (o_count == e.count) else begin
		$display("Mismatch at %0t: job %0d o_count %0d, expected %0d", $time, done_cnt,
			o_count, e.count);
		errors++;
	end
endtask

// Sampled mid-cycle, a transfer seen here lands on the next rising edge
always @(negedge clk) begin
	if (reset === 1'b0) begin
		if (i_valid && o_ready) begin
			if (accepted_cnt > done_cnt)
				overlap_seen = 1'b1;
			exp_q.push_back(ref_compact(i_act, i_wgt, i_act_mask, i_wgt_mask));
			accepted_cnt++;
		end
		if (o_valid && holding) begin
			checks++;
			assert (o_act == held.act && o_wgt == held.wgt && o_mask == held.mask &&
				o_count == held.count) else begin
				$display("Mismatch at %0t: output changed while i_ready was low", $time);
				errors++;
			end
		end
		if (o_valid && i_ready) begin
			holding = 1'b0;
			checks++;
			assert (exp_q.size() != 0) else begin
				$display("Error: an output job arrived with no accepted job pending");
				errors++;
			end
			if (exp_q.size() != 0) begin
				exp_r = exp_q.pop_front();
				compare_result(exp_r);
			end
			done_cnt++;
		end
		else if (o_valid) begin
			holding = 1'b1;
			held = {o_act, o_wgt, o_mask, o_count};
		end
	end
end

////////////////////
// Main sequence and watchdog

initial begin
	$timeformat(-9, 0, " ns", 0);
	reset = 1'b1;
	i_valid = 1'b0;
	i_act = '0;
	i_wgt = '0;
	i_act_mask = '0;
	i_wgt_mask = '0;
	i_ready = 1'b1;
	bp_enable = 1'b0;
	bp_left = 0;
	data_rng = 32'd98;
	rdy_rng = 32'd98;
	errors = 0;
	checks = 0;
	accepted_cnt = 0;
	done_cnt = 0;
	overlap_seen = 1'b0;
	holding = 1'b0;
	held = '0;
	repeat (3) @(posedge clk);
	reset <= 1'b0;
	@(posedge clk);
	run_test(1, "all-ones masks", N_ALL_ONES, 1);
	run_test(2, "disjoint masks", N_DISJOINT, 2);
	run_test(3, "random jobs", N_RANDOM, 3);
	run_test(4, "back-pressure", N_BACKPRESSURE, 4);
	run_test(5, "back-to-back", N_BURST, 5);
	checks++;
	assert (done_cnt == N_JOBS) else begin
		$display("Error: %0d jobs came out, %0d were sent", done_cnt, N_JOBS);
		errors++;
	end
	$display("Summary: %0d jobs, %0d checks, %0d errors", done_cnt, checks, errors);
	if (errors == 0) begin
		$display("ALL CHECKS PASSED");
	end
	else begin
		$display("CHECKS FAILED");
	end
	$finish;
end

initial begin
	#(LIMIT_CYCLES * CLK_NS);
	$display("Timeout: the jobs did not all come out within %0d cycles", LIMIT_CYCLES);
	$display("CHECKS FAILED");
	$finish;
end

endmodule

// File: verilog.f
+incdir+rtl
rtl/sparse_data_pkg.sv
rtl/sparse_ctrl_pkg.sv
rtl/lane_filter.sv
rtl/pair_compactor.sv
rtl/sparsity_top.sv
sim/tb_sparsity.sv

// File: run.sh
#!/bin/sh
# Build and run the sparsity unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f --top-module tb_sparsity -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
echo "Simulation reported failure"
exit 1
